// File: Makefile
TOP = tb_udma_hyperbus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall --top-module udma_hyperbus -f sources.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// File: design/hyper_2d_splitter.sv
/* Cuts a 2D command into 1D transactions of chunk bytes, stepping by stride.
   1D commands and a zero chunk go through as one transaction */
`timescale 1ns/1ps
`default_nettype none

module hyper_2d_splitter
   import hyper_pkg::*;
(
   input  logic     sys_clk_i,
   input  logic     rst_i,

   hyper_cmd_if.dst cmd_i,
   hyper_cmd_if.src trans_o
);

   split_state_e state_q;
   hyper_addr_t  addr_q;
   trans_size_t  rem_q;
   trans_size_t  chunk_q;
   trans_size_t  stride_q;
   logic         write_q;
   ch_id_t       id_q;
   logic         piece_last;
   logic         cmd_fire;
   logic         trans_fire;

   assign cmd_i.ready = (state_q == SPLIT_IDLE);
   assign cmd_fire    = cmd_i.valid && cmd_i.ready;
   assign trans_fire  = trans_o.valid && trans_o.ready;
   assign piece_last  = (rem_q <= chunk_q);

   assign trans_o.valid  = (state_q == SPLIT_EMIT);
   assign trans_o.addr   = addr_q;
   assign trans_o.size   = piece_last ? rem_q : chunk_q;
   assign trans_o.write  = write_q;
   assign trans_o.two_d  = 1'b0;
   assign trans_o.chunk  = chunk_q;
   assign trans_o.stride = stride_q;
   assign trans_o.id     = id_q;
   assign trans_o.last   = piece_last;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         state_q <= SPLIT_IDLE;
      else
      begin
         case (state_q)
            SPLIT_IDLE: if (cmd_fire) state_q <= SPLIT_EMIT;
            SPLIT_EMIT: if (trans_fire && piece_last) state_q <= SPLIT_IDLE;
            default:    state_q <= SPLIT_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (cmd_fire)
      begin
         addr_q   <= cmd_i.addr;
         rem_q    <= cmd_i.size;
         // Single piece: chunk equal to size makes the first piece the last
         chunk_q  <= (cmd_i.two_d && cmd_i.chunk != '0) ? cmd_i.chunk : cmd_i.size;
         stride_q <= cmd_i.stride;
         write_q  <= cmd_i.write;
         id_q     <= cmd_i.id;
      end
      else if (trans_fire && !piece_last)
      begin
         addr_q <= addr_q + hyper_addr_t'(stride_q);
         rem_q  <= rem_q - chunk_q;
      end
   end

endmodule

`default_nettype wire

// File: design/hyper_cmd_if.sv
/* One command or 1D transaction with a valid/ready handshake.
   Producer keeps valid and payload stable until ready is seen */
`timescale 1ns/1ps
`default_nettype none

interface hyper_cmd_if
   import hyper_pkg::*;
();

   logic        valid;
   logic        ready;
   hyper_addr_t addr;
   trans_size_t size;
   logic        write;
   logic        two_d;
   trans_size_t chunk;
   trans_size_t stride;
   ch_id_t      id;
   logic        last;

   modport src (
      output valid, addr, size, write, two_d, chunk, stride, id, last,
      input  ready
   );

   modport dst (
      input  valid, addr, size, write, two_d, chunk, stride, id, last,
      output ready
   );

endinterface

`default_nettype wire

// File: design/hyper_cmd_queue.sv
/* Register window of one channel, holds at most one pending command.
   A start write is stalled while the previous command waits for its grant */
`timescale 1ns/1ps
`default_nettype none

module hyper_cmd_queue
   import hyper_pkg::*;
(
   input  logic        sys_clk_i,
   input  logic        rst_i,

   input  logic        cfg_valid_i,
   input  cfg_addr_t   cfg_addr_i,
   input  cfg_data_t   cfg_data_i,
   input  logic        cfg_rwn_i,
   output logic        cfg_ready_o,
   output cfg_data_t   cfg_data_o,

   output logic        cmd_valid_o,
   input  logic        cmd_grant_i,
   output hyper_addr_t cmd_addr_o,
   output trans_size_t cmd_size_o,
   output logic [1:0]  cmd_mode_o,
   output trans_size_t cmd_chunk_o,
   output trans_size_t cmd_stride_o
);

   hyper_addr_t addr_q;
   trans_size_t size_q;
   logic [1:0]  mode_q;
   trans_size_t chunk_q;
   trans_size_t stride_q;
   logic        pending_q;
   logic        wr_en;

   assign cfg_ready_o = !(!cfg_rwn_i && cfg_addr_i == REG_START && pending_q);
   assign wr_en       = cfg_valid_i && cfg_ready_o && !cfg_rwn_i;

   always_comb
   begin
      case (cfg_addr_i)
         REG_ADDR:   cfg_data_o = addr_q;
         REG_SIZE:   cfg_data_o = cfg_data_t'(size_q);
         REG_MODE:   cfg_data_o = cfg_data_t'(mode_q);
         REG_CHUNK:  cfg_data_o = cfg_data_t'(chunk_q);
         REG_STRIDE: cfg_data_o = cfg_data_t'(stride_q);
         REG_START:  cfg_data_o = cfg_data_t'(pending_q);
         default:    cfg_data_o = '0;
      endcase
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         addr_q    <= '0;
         size_q    <= '0;
         mode_q    <= '0;
         chunk_q   <= '0;
         stride_q  <= '0;
         pending_q <= 1'b0;
      end
      else
      begin
         if (wr_en)
         begin
            case (cfg_addr_i)
               REG_ADDR:   addr_q   <= cfg_data_i;
               REG_SIZE:   size_q   <= cfg_data_i[15:0];
               REG_MODE:   mode_q   <= cfg_data_i[1:0];
               REG_CHUNK:  chunk_q  <= cfg_data_i[15:0];
               REG_STRIDE: stride_q <= cfg_data_i[15:0];
               default:    ;
            endcase
         end
         // Grant and start are exclusive, start needs pending low
         if (cmd_grant_i)
            pending_q <= 1'b0;
         else if (wr_en && cfg_addr_i == REG_START)
            pending_q <= 1'b1;
      end
   end

   // Snapshot so software may reprogram while the command waits
   always_ff @(posedge sys_clk_i)
   begin
      if (wr_en && cfg_addr_i == REG_START)
      begin
         cmd_addr_o   <= addr_q;
         cmd_size_o   <= size_q;
         cmd_mode_o   <= mode_q;
         cmd_chunk_o  <= chunk_q;
         cmd_stride_o <= stride_q;
      end
   end

   assign cmd_valid_o = pending_q;

   // Arbiter only grants a command this queue really holds
   a_grant_pending: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      cmd_grant_i |-> pending_q);

endmodule

`default_nettype wire

// File: design/hyper_pkg.sv
/* Shared widths, register map and types of the HyperBus command path.
   Chip select decodes a single address bit, so only two chips are reachable */
`default_nettype none

package hyper_pkg;

   localparam int NB_CH        = 2;
   localparam int CH_ID_W      = 1;
   localparam int NUM_CHIPS    = 2;
   localparam int CHIP_SEL_BIT = 24;
   localparam int FIFO_DEPTH   = 4;
   localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

   typedef logic [31:0]          hyper_addr_t;
   typedef logic [15:0]          trans_size_t;
   typedef logic [15:0]          burst_len_t;
   typedef logic [31:0]          cfg_data_t;
   typedef logic [4:0]           cfg_addr_t;
   typedef logic [CH_ID_W-1:0]   ch_id_t;
   typedef logic [NUM_CHIPS-1:0] chip_sel_t;

   typedef enum logic {SPLIT_IDLE, SPLIT_EMIT} split_state_e;

   // Channel register window
   localparam cfg_addr_t REG_ADDR   = 5'd0;
   localparam cfg_addr_t REG_SIZE   = 5'd1;
   localparam cfg_addr_t REG_MODE   = 5'd2;
   localparam cfg_addr_t REG_CHUNK  = 5'd3;
   localparam cfg_addr_t REG_STRIDE = 5'd4;
   localparam cfg_addr_t REG_START  = 5'd5;

   // Bits of REG_MODE
   localparam int MODE_WRITE_BIT = 0;
   localparam int MODE_2D_BIT    = 1;

   // addr, size, chunk, stride, id, then write, two_d and last
   localparam int TRANS_ENTRY_W = $bits(hyper_addr_t) + 3 * $bits(trans_size_t) + CH_ID_W + 3;

endpackage

`default_nettype wire

// File: design/hyper_rr_arbiter.sv
/* Round-robin pick among pending channel commands, purely combinational path.
   Priority moves past the granted channel only when the command is taken */
`timescale 1ns/1ps
`default_nettype none

module hyper_rr_arbiter
   import hyper_pkg::*;
(
   input  logic                          sys_clk_i,
   input  logic                          rst_i,

   input  logic        [NB_CH-1:0]       req_i,
   input  hyper_addr_t [NB_CH-1:0]       addr_i,
   input  trans_size_t [NB_CH-1:0]       size_i,
   input  logic        [NB_CH-1:0][1:0]  mode_i,
   input  trans_size_t [NB_CH-1:0]       chunk_i,
   input  trans_size_t [NB_CH-1:0]       stride_i,
   output logic        [NB_CH-1:0]       grant_o,

   hyper_cmd_if.src                      cmd_o
);

   ch_id_t ptr_q;
   ch_id_t sel_idx;
   logic   sel_found;
   logic   fire;

   // First requester at or after the pointer
   always_comb
   begin
      int cand;
      sel_found = 1'b0;
      sel_idx   = '0;
      for (int i = 0; i < NB_CH; i++)
      begin
         cand = (int'(ptr_q) + i) % NB_CH;
         if (!sel_found && req_i[cand])
         begin
            sel_found = 1'b1;
            sel_idx   = ch_id_t'(cand);
         end
      end
   end

   assign cmd_o.valid  = sel_found;
   assign cmd_o.addr   = addr_i[sel_idx];
   assign cmd_o.size   = size_i[sel_idx];
   assign cmd_o.write  = mode_i[sel_idx][MODE_WRITE_BIT];
   assign cmd_o.two_d  = mode_i[sel_idx][MODE_2D_BIT];
   assign cmd_o.chunk  = chunk_i[sel_idx];
   assign cmd_o.stride = stride_i[sel_idx];
   assign cmd_o.id     = sel_idx;
   assign cmd_o.last   = 1'b1;

   assign fire = cmd_o.valid && cmd_o.ready;

   always_comb
   begin
      for (int i = 0; i < NB_CH; i++)
         grant_o[i] = fire && (sel_idx == ch_id_t'(i));
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         ptr_q <= '0;
      else if (fire)
         ptr_q <= (sel_idx == ch_id_t'(NB_CH - 1)) ? '0 : sel_idx + 1'b1;
   end

   a_grant_onehot: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      $onehot0(grant_o));

endmodule

`default_nettype wire

// File: design/hyper_trans_fifo.sv
/* Small synchronous FIFO of 1D transactions, output read straight from storage.
   Full blocks pushes even when a pop happens in the same cycle */
`timescale 1ns/1ps
`default_nettype none

module hyper_trans_fifo
   import hyper_pkg::*;
(
   input  logic     sys_clk_i,
   input  logic     rst_i,

   hyper_cmd_if.dst push_i,
   hyper_cmd_if.src pop_o
);

   logic [TRANS_ENTRY_W-1:0] mem_q [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0]    wr_ptr_q;
   logic [FIFO_PTR_W-1:0]    rd_ptr_q;
   logic [FIFO_PTR_W:0]      count_q;
   logic                     do_push;
   logic                     do_pop;

   assign push_i.ready = (count_q < FIFO_DEPTH);
   assign pop_o.valid  = (count_q != '0);
   assign do_push      = push_i.valid && push_i.ready;
   assign do_pop       = pop_o.valid && pop_o.ready;

   assign {pop_o.addr, pop_o.size, pop_o.chunk, pop_o.stride, pop_o.id,
           pop_o.write, pop_o.two_d, pop_o.last} = mem_q[rd_ptr_q];

   always_ff @(posedge sys_clk_i)
   begin
      if (do_push)
         mem_q[wr_ptr_q] <= {push_i.addr, push_i.size, push_i.chunk, push_i.stride,
                             push_i.id, push_i.write, push_i.two_d, push_i.last};
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_push && !do_pop)
            count_q <= count_q + 1'b1;
         else if (do_pop && !do_push)
            count_q <= count_q - 1'b1;
      end
   end

   // Count never passes the depth, so nothing is pushed into a full buffer
   a_no_push_full: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      count_q <= FIFO_DEPTH);

   // Pointers agree with the count, so an empty buffer is never read
   a_no_pop_empty: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      (wr_ptr_q - rd_ptr_q) == count_q[FIFO_PTR_W-1:0]);

endmodule

`default_nettype wire

// File: design/hyper_trans_issue.sv
/* Output register toward the PHY, burst counted in 16-bit words rounded up.
   EOT pulses one cycle after the PHY takes the last piece of a command */
`timescale 1ns/1ps
`default_nettype none

module hyper_trans_issue
   import hyper_pkg::*;
(
   input  logic             sys_clk_i,
   input  logic             rst_i,

   hyper_cmd_if.dst         trans_i,

   output logic             trans_valid_o,
   input  logic             trans_ready_i,
   output hyper_addr_t      trans_addr_o,
   output burst_len_t       trans_burst_o,
   output logic             trans_write_o,
   output chip_sel_t        trans_cs_o,
   output logic [NB_CH-1:0] evt_eot_o
);

   logic             load;
   logic             out_valid_q;
   logic             last_q;
   ch_id_t           id_q;
   logic [NB_CH-1:0] eot_q;
   burst_len_t       burst_d;
   chip_sel_t        cs_d;

   assign load          = !out_valid_q || trans_ready_i;
   assign trans_i.ready = load;

   assign burst_d = burst_len_t'(({1'b0, trans_i.size} + 17'd1) >> 1);
   assign cs_d    = chip_sel_t'(1) << trans_i.addr[CHIP_SEL_BIT];

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         out_valid_q <= 1'b0;
         eot_q       <= '0;
      end
      else
      begin
         eot_q <= '0;
         if (out_valid_q && trans_ready_i && last_q)
            eot_q[id_q] <= 1'b1;
         if (load)
            out_valid_q <= trans_i.valid;
      end
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (load && trans_i.valid)
      begin
         trans_addr_o  <= trans_i.addr;
         trans_burst_o <= burst_d;
         trans_write_o <= trans_i.write;
         trans_cs_o    <= cs_d;
         last_q        <= trans_i.last;
         id_q          <= trans_i.id;
      end
   end

   assign trans_valid_o = out_valid_q;
   assign evt_eot_o     = eot_q;

endmodule

`default_nettype wire

// File: design/udma_hyperbus.sv
/* Command side of the uDMA HyperBus front-end, one clock domain.
   No data path here, the PHY only sees transaction requests */
`timescale 1ns/1ps
`default_nettype none

module udma_hyperbus
   import hyper_pkg::*;
(
   input  logic                    sys_clk_i,
   input  logic                    rst_i,

   input  logic      [NB_CH-1:0]   cfg_valid_i,
   input  cfg_addr_t               cfg_addr_i,
   input  cfg_data_t               cfg_data_i,
   input  logic                    cfg_rwn_i,
   output logic      [NB_CH-1:0]   cfg_ready_o,
   output cfg_data_t [NB_CH-1:0]   cfg_data_o,

   output logic                    trans_valid_o,
   input  logic                    trans_ready_i,
   output hyper_addr_t             trans_addr_o,
   output burst_len_t              trans_burst_o,
   output logic                    trans_write_o,
   output chip_sel_t               trans_cs_o,
   output logic      [NB_CH-1:0]   evt_eot_o
);

   logic        [NB_CH-1:0]      q_valid;
   logic        [NB_CH-1:0]      q_grant;
   hyper_addr_t [NB_CH-1:0]      q_addr;
   trans_size_t [NB_CH-1:0]      q_size;
   logic        [NB_CH-1:0][1:0] q_mode;
   trans_size_t [NB_CH-1:0]      q_chunk;
   trans_size_t [NB_CH-1:0]      q_stride;

   hyper_cmd_if arb_cmd   ();
   hyper_cmd_if split_out ();
   hyper_cmd_if fifo_out  ();

////////////////////////////////////////////////////////////////////////////
// Channel register windows
////////////////////////////////////////////////////////////////////////////

   for (genvar g = 0; g < NB_CH; g++)
   begin : g_ch
      hyper_cmd_queue u_cmd_queue (
         .sys_clk_i    ( sys_clk_i      ),
         .rst_i        ( rst_i          ),
         .cfg_valid_i  ( cfg_valid_i[g] ),
         .cfg_addr_i   ( cfg_addr_i     ),
         .cfg_data_i   ( cfg_data_i     ),
         .cfg_rwn_i    ( cfg_rwn_i      ),
         .cfg_ready_o  ( cfg_ready_o[g] ),
         .cfg_data_o   ( cfg_data_o[g]  ),
         .cmd_valid_o  ( q_valid[g]     ),
         .cmd_grant_i  ( q_grant[g]     ),
         .cmd_addr_o   ( q_addr[g]      ),
         .cmd_size_o   ( q_size[g]      ),
         .cmd_mode_o   ( q_mode[g]      ),
         .cmd_chunk_o  ( q_chunk[g]     ),
         .cmd_stride_o ( q_stride[g]    )
      );
   end

////////////////////////////////////////////////////////////////////////////
// Arbitration, splitting and issue
////////////////////////////////////////////////////////////////////////////

   hyper_rr_arbiter u_arbiter (
      .sys_clk_i ( sys_clk_i ),
      .rst_i     ( rst_i     ),
      .req_i     ( q_valid   ),
      .addr_i    ( q_addr    ),
      .size_i    ( q_size    ),
      .mode_i    ( q_mode    ),
      .chunk_i   ( q_chunk   ),
      .stride_i  ( q_stride  ),
      .grant_o   ( q_grant   ),
      .cmd_o     ( arb_cmd   )
   );

   hyper_2d_splitter u_splitter (
      .sys_clk_i ( sys_clk_i ),
      .rst_i     ( rst_i     ),
      .cmd_i     ( arb_cmd   ),
      .trans_o   ( split_out )
   );

   hyper_trans_fifo u_trans_fifo (
      .sys_clk_i ( sys_clk_i ),
      .rst_i     ( rst_i     ),
      .push_i    ( split_out ),
      .pop_o     ( fifo_out  )
   );

   hyper_trans_issue u_issue (
      .sys_clk_i     ( sys_clk_i     ),
      .rst_i         ( rst_i         ),
      .trans_i       ( fifo_out      ),
      .trans_valid_o ( trans_valid_o ),
      .trans_ready_i ( trans_ready_i ),
      .trans_addr_o  ( trans_addr_o  ),
      .trans_burst_o ( trans_burst_o ),
      .trans_write_o ( trans_write_o ),
      .trans_cs_o    ( trans_cs_o    ),
      .evt_eot_o     ( evt_eot_o     )
   );

endmodule

`default_nettype wire

// File: sources.f
design/hyper_pkg.sv
design/hyper_cmd_if.sv
design/hyper_cmd_queue.sv
design/hyper_rr_arbiter.sv
design/hyper_2d_splitter.sv
design/hyper_trans_fifo.sv
design/hyper_trans_issue.sv
design/udma_hyperbus.sv
tb/tb_clk_gen.sv
tb/tb_udma_hyperbus.sv

// File: tb/tb_clk_gen.sv
/* Clock of 100 ns period, reset high for the first 8 rising edges */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   // Released on a falling edge, away from the DUT sampling edge
   initial
   begin
      rst_o = 1'b1;
      repeat (8) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire

// File: tb/tb_udma_hyperbus.sv
/* Random commands on both channels, checked against per-channel request queues.
   Channel addresses differ in bit 28, so each PHY request maps to one channel */
`timescale 1ns/1ps
`default_nettype none

module tb_udma_hyperbus
   import hyper_pkg::*;
();

   localparam int READY_HIGH  = 0;
   localparam int READY_LOW   = 1;
   localparam int READY_RAND  = 2;
   localparam int N_CMDS      = 36;
   localparam int MAX_PIECES  = 8;
   localparam int CYCLE_LIMIT = N_CMDS * (12 + 4 * MAX_PIECES) * 2 + 500;

   typedef struct packed {
      hyper_addr_t addr;
      burst_len_t  burst;
      logic        write;
      chip_sel_t   cs;
      logic        last;
   } exp_req_t;

   logic                  sys_clk;
   logic                  rst;
   logic      [NB_CH-1:0] cfg_valid;
   cfg_addr_t             cfg_addr;
   cfg_data_t             cfg_data;
   logic                  cfg_rwn;
   logic      [NB_CH-1:0] cfg_ready;
   cfg_data_t [NB_CH-1:0] cfg_rdata;
   logic                  trans_valid;
   logic                  trans_ready = 1'b1;
   hyper_addr_t           trans_addr;
   burst_len_t            trans_burst;
   logic                  trans_write;
   chip_sel_t             trans_cs;
   logic      [NB_CH-1:0] evt_eot;

   integer      seed = 32'hf74d;
   int          errors = 0;
   int          tests = 0;
   int          test_err_start = 0;
   int          cycles = 0;
   int          ready_mode = READY_HIGH;
   exp_req_t    exp_q [NB_CH][$];
   int          eot_exp [NB_CH] = '{default: 0};
   int          eot_due [NB_CH] = '{default: 0};
   int          eot_seen [NB_CH] = '{default: 0};
   logic        hold_q = 1'b0;
   hyper_addr_t held_addr = '0;

   tb_clk_gen u_clk_gen (
      .clk_o ( sys_clk ),
      .rst_o ( rst     )
   );

   udma_hyperbus dut_i (
      .sys_clk_i     ( sys_clk     ),
      .rst_i         ( rst         ),
      .cfg_valid_i   ( cfg_valid   ),
      .cfg_addr_i    ( cfg_addr    ),
      .cfg_data_i    ( cfg_data    ),
      .cfg_rwn_i     ( cfg_rwn     ),
      .cfg_ready_o   ( cfg_ready   ),
      .cfg_data_o    ( cfg_rdata   ),
      .trans_valid_o ( trans_valid ),
      .trans_ready_i ( trans_ready ),
      .trans_addr_o  ( trans_addr  ),
      .trans_burst_o ( trans_burst ),
      .trans_write_o ( trans_write ),
      .trans_cs_o    ( trans_cs    ),
      .evt_eot_o     ( evt_eot     )
   );

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

   task automatic check_addr(input string name, input hyper_addr_t got, input hyper_addr_t exp);
      if (got !== exp)
      begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_burst(input string name, input burst_len_t got, input burst_len_t exp);
      if (got !== exp)
      begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_cs(input string name, input chip_sel_t got, input chip_sel_t exp);
      if (got !== exp)
      begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_data(input string name, input cfg_data_t got, input cfg_data_t exp);
      if (got !== exp)
      begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

////////////////////////////////////////////////////////////////////////////
// Reference model and PHY side monitor
////////////////////////////////////////////////////////////////////////////

   // Expected requests of one command, split by chunk and stepped by stride
   task automatic model_push(input int ch, input hyper_addr_t addr, input trans_size_t size,
                             input logic [1:0] mode, input trans_size_t chunk,
                             input trans_size_t stride);
      exp_req_t e;
      int       rem;
      int       len;
      int       step;
      rem  = int'(size);
      step = (mode[1] && chunk != 0) ? int'(chunk) : rem;
      e.addr = addr;
      e.write = mode[0];
      do
      begin
         len     = (rem > step) ? step : rem;
         e.last  = (rem <= step);
         e.burst = burst_len_t'((len + 1) / 2);
         e.cs    = e.addr[CHIP_SEL_BIT] ? 2'b10 : 2'b01;
         exp_q[ch].push_back(e);
         e.addr = e.addr + hyper_addr_t'(stride);
         rem    = rem - len;
      end
      while (!e.last);
      eot_exp[ch]++;
   endtask

   always @(posedge sys_clk)
   begin : monitor
      int       hits;
      int       hit_ch;
      exp_req_t head;
      if (!rst)
      begin
         // EOT first, it belongs to an acceptance on an earlier edge
         for (int ch = 0; ch < NB_CH; ch++)
         begin
            if (evt_eot[ch] && eot_due[ch] == 0)
            begin
               $display("EOT on channel %0d without a finished command", ch);
               errors++;
            end
            else if (evt_eot[ch])
            begin
               eot_due[ch]--;
               eot_seen[ch]++;
            end
         end
         if (hold_q)
         begin
            check_bit("trans_valid_o", trans_valid, 1'b1);
            check_addr("trans_addr_o", trans_addr, held_addr);
         end
         if (trans_valid && trans_ready)
         begin
            hits   = 0;
            hit_ch = 0;
            for (int ch = 0; ch < NB_CH; ch++)
            begin
               if (exp_q[ch].size() > 0 && exp_q[ch][0].addr == trans_addr)
               begin
                  hits++;
                  hit_ch = ch;
               end
            end
            if (hits != 1)
            begin
               $display("Request at 0x%h matches %0d expected heads", trans_addr, hits);
               errors++;
            end
            else
            begin
               head = exp_q[hit_ch].pop_front();
               check_burst("trans_burst_o", trans_burst, head.burst);
               check_bit("trans_write_o", trans_write, head.write);
               check_cs("trans_cs_o", trans_cs, head.cs);
               if (head.last)
                  eot_due[hit_ch]++;
            end
         end
         hold_q    = trans_valid && !trans_ready;
         held_addr = trans_addr;
      end
   end

   always @(negedge sys_clk)
   begin
      if (ready_mode == READY_RAND)
         trans_ready = ($random(seed) % 2 != 0);
      else
         trans_ready = (ready_mode == READY_HIGH);
   end

   always @(posedge sys_clk)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("Run stopped after %0d cycles, traffic did not drain", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

////////////////////////////////////////////////////////////////////////////
// Stimulus, called just after a falling edge
////////////////////////////////////////////////////////////////////////////

   // Ready and read data are sampled mid low phase, before the completing edge
   task automatic cfg_access(input int ch, input logic rwn, input cfg_addr_t addr,
                             input cfg_data_t wdata, output cfg_data_t rdata,
                             output int waits);
      waits         = 0;
      cfg_valid     = '0;
      cfg_valid[ch] = 1'b1;
      cfg_addr      = addr;
      cfg_data      = wdata;
      cfg_rwn       = rwn;
      #10;
      while (!cfg_ready[ch])
      begin
         waits++;
         @(negedge sys_clk);
         #10;
      end
      rdata = cfg_rdata[ch];
      @(negedge sys_clk);
      cfg_valid = '0;
   endtask

   task automatic issue_cmd(input int ch, input hyper_addr_t addr, input trans_size_t size,
                            input logic [1:0] mode, input trans_size_t chunk,
                            input trans_size_t stride, output int waits);
      cfg_data_t rd;
      model_push(ch, addr, size, mode, chunk, stride);
      cfg_access(ch, 1'b0, REG_ADDR, addr, rd, waits);
      cfg_access(ch, 1'b0, REG_SIZE, cfg_data_t'(size), rd, waits);
      cfg_access(ch, 1'b0, REG_MODE, cfg_data_t'(mode), rd, waits);
      cfg_access(ch, 1'b0, REG_CHUNK, cfg_data_t'(chunk), rd, waits);
      cfg_access(ch, 1'b0, REG_STRIDE, cfg_data_t'(stride), rd, waits);
      cfg_access(ch, 1'b0, REG_START, 32'h1, rd, waits);
   endtask

   // At most MAX_PIECES pieces, since chunk is never below size / 8
   task automatic rand_cmd(input int ch, input logic two_d, input logic zero_chunk);
      hyper_addr_t addr;
      int          size;
      int          chunk;
      cfg_data_t   r;
      int          waits;
      addr  = (hyper_addr_t'(ch) << 28) | (hyper_addr_t'($random(seed)) & 32'h01ff_ffff);
      size  = ($random(seed) & 32'h1ff) + 1;
      chunk = two_d ? (size + 7) / 8 + ($random(seed) & 32'h3f) : ($random(seed) & 32'hff);
      if (zero_chunk)
         chunk = 0;
      r = $random(seed);
      issue_cmd(ch, addr, trans_size_t'(size), {two_d, r[0]}, trans_size_t'(chunk),
                trans_size_t'(r[25:16]), waits);
   endtask

   task automatic wait_drain();
      logic busy;
      busy = 1'b1;
      while (busy)
      begin
         @(negedge sys_clk);
         busy = 1'b0;
         for (int ch = 0; ch < NB_CH; ch++)
            if (exp_q[ch].size() != 0 || eot_seen[ch] != eot_exp[ch])
               busy = 1'b1;
      end
      repeat (4) @(negedge sys_clk);
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors == test_err_start)
         $display("Test %0d %s: pass", tests, name);
      else
         $display("Test %0d %s: %0d mismatches", tests, name, errors - test_err_start);
      test_err_start = errors;
   endtask

////////////////////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////////////////////

   task automatic run_readback();
      cfg_addr_t regs [5];
      cfg_data_t mask [5];
      cfg_data_t wval [5];
      cfg_data_t rd;
      int        w;
      regs = '{REG_ADDR, REG_SIZE, REG_MODE, REG_CHUNK, REG_STRIDE};
      mask = '{32'hffff_ffff, 32'h0000_ffff, 32'h0000_0003, 32'h0000_ffff, 32'h0000_ffff};
      check_bit("trans_valid_o", trans_valid, 1'b0);
      for (int ch = 0; ch < NB_CH; ch++)
      begin
         check_bit("evt_eot_o", evt_eot[ch], 1'b0);
         check_bit("cfg_ready_o", cfg_ready[ch], 1'b1);
         cfg_access(ch, 1'b1, REG_START, '0, rd, w);
         check_data("cfg_data_o pending", rd, '0);
         for (int r = 0; r < 5; r++)
         begin
            wval[r] = $random(seed);
            cfg_access(ch, 1'b0, regs[r], wval[r], rd, w);
         end
         for (int r = 0; r < 5; r++)
         begin
            cfg_access(ch, 1'b1, regs[r], '0, rd, w);
            check_data($sformatf("cfg_data_o[%0d] reg %0d", ch, regs[r]), rd, wval[r] & mask[r]);
         end
      end
   endtask

   task automatic run_concurrent();
      int waits;
      ready_mode = READY_LOW;
      // Eight pieces fill the issue register and FIFO and stall the splitter
      issue_cmd(0, 32'h0000_4000, 16'd512, 2'b11, 16'd64, 16'd256, waits);
      issue_cmd(1, 32'h1100_0000, 16'd33, 2'b00, 16'd0, 16'd0, waits);
      fork
         issue_cmd(1, 32'h1000_2000, 16'd96, 2'b10, 16'd32, 16'd128, waits);
         begin
            repeat (20) @(negedge sys_clk);
            ready_mode = READY_RAND;
         end
      join
      if (waits == 0)
      begin
         $display("Start write on a channel with a pending command was not stalled");
         errors++;
      end
      for (int i = 0; i < 8; i++)
         rand_cmd(i % NB_CH, 1'b1, 1'b0);
      wait_drain();
   endtask

   initial
   begin
      cfg_valid = '0;
      cfg_addr  = '0;
      cfg_data  = '0;
      cfg_rwn   = 1'b1;
      @(negedge sys_clk);
      while (rst)
         @(negedge sys_clk);

      run_readback();
      finish_test("register readback");

      for (int i = 0; i < 6; i++)
      begin
         rand_cmd(i % NB_CH, 1'b0, 1'b0);
         wait_drain();
      end
      finish_test("1D commands");

      for (int i = 0; i < 6; i++)
      begin
         rand_cmd(i % NB_CH, 1'b1, i == 0);
         wait_drain();
      end
      finish_test("2D commands");

      ready_mode = READY_RAND;
      for (int i = 0; i < 10; i++)
         rand_cmd($random(seed) & 1, ($random(seed) & 1) != 0, 1'b0);
      wait_drain();
      finish_test("PHY back-pressure");

      run_concurrent();
      finish_test("concurrent channels");

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
